// ==== design/e31x_ctrl_pkg.sv ====
// E31x control package
// Shared widths, bit positions, stretch length and the power button
// state encoding for the bus_clk housekeeping logic of the E31x top level.

package e31x_ctrl_pkg;

  //////////////////////////////////////////////////////////////////////
  // Register and GPIO widths
  //////////////////////////////////////////////////////////////////////

  // Daughterboard status word
  localparam int reg_dwidth = 32;

  // One channel's GPIO word from the radio core
  localparam int db_gpio_width = 32;

  // One radio with two channels
  localparam int num_channels = 2;

  //////////////////////////////////////////////////////////////////////
  // Interrupt vector to the processor
  //////////////////////////////////////////////////////////////////////

  localparam int irq_width = 16;

  // Bit 0 and bits 4 and up are unused
  localparam int irq_bit_press   = 1;
  localparam int irq_bit_release = 2;
  localparam int irq_bit_pmu     = 3;

  // Stretched interrupt length in bus_clk cycles
  localparam int irq_stretch_cycles = 8;

  // Wide enough to hold irq_stretch_cycles
  typedef logic [3:0] stretch_cnt_t;

  //////////////////////////////////////////////////////////////////////
  // Daughterboard status word layout
  //////////////////////////////////////////////////////////////////////

  // Reference status {plllck, is_10meg, is_pps, reflck}
  localparam int tcxo_status_width = 4;

  localparam int stat_bit_rx_lock = 6;
  localparam int stat_bit_tx_lock = 7;
  localparam int stat_tcxo_lsb    = 8;

  //////////////////////////////////////////////////////////////////////
  // Front-end mapping
  //////////////////////////////////////////////////////////////////////

  // TX enables inside a channel's GPIO word
  localparam int gpio_bit_tx_enable_a = 10;
  localparam int gpio_bit_tx_enable_b = 11;

  // LED bits used per channel: txrx_rx, txrx_tx, rx_rx
  localparam int led_width = 3;

  // Power button states, down means the line is low
  typedef enum logic [1:0] {
    btn_down,
    btn_down_confirm,
    btn_up,
    btn_up_confirm
  } btn_state_t;

endpackage

// ==== design/power_button_fsm.sv ====
// Power button edge detector
// Tracks the debounced, active-low button line and emits a one-cycle
// press pulse on a low sample after two high samples, and a one-cycle
// release pulse on a high sample after two low samples.

`timescale 1ns/1ps

module power_button_fsm (
  input  logic bus_clk,
  input  logic bus_rst,
  input  logic onswitch_n,
  output logic press_pulse,
  output logic release_pulse
);

  import e31x_ctrl_pkg::*;

  btn_state_t state;
  btn_state_t state_next;
  logic       press_next;
  logic       release_next;

  //////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_next   = state;
    press_next   = 1'b0;
    release_next = 1'b0;
    case (state)
      btn_down: begin
        // Line was low twice, a high sample is a release
        if (onswitch_n) begin
          state_next   = btn_up_confirm;
          release_next = 1'b1;
        end
      end
      btn_down_confirm: begin
        if (onswitch_n) begin
          state_next = btn_up_confirm;
        end else begin
          state_next = btn_down;
        end
      end
      btn_up: begin
        // Line was high twice, a low sample is a press
        if (!onswitch_n) begin
          state_next = btn_down_confirm;
          press_next = 1'b1;
        end
      end
      btn_up_confirm: begin
        if (onswitch_n) begin
          state_next = btn_up;
        end else begin
          state_next = btn_down_confirm;
        end
      end
      default: begin
        state_next = btn_down;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // State and pulse registers
  //////////////////////////////////////////////////////////////////////

  // Starting in btn_down reports a released button once after reset
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      state         <= btn_down;
      press_pulse   <= 1'b0;
      release_pulse <= 1'b0;
    end else begin
      state         <= state_next;
      press_pulse   <= press_next;
      release_pulse <= release_next;
    end
  end

endmodule

// ==== design/irq_stretch_timer.sv ====
// Interrupt pulse stretcher
// Turns a one-cycle pulse into an interrupt level that stays high for
// irq_stretch_cycles cycles after the most recent pulse.

`timescale 1ns/1ps

module irq_stretch_timer (
  input  logic bus_clk,
  input  logic bus_rst,
  input  logic pulse,
  output logic irq_level
);

  import e31x_ctrl_pkg::*;

  localparam stretch_cnt_t cnt_load = stretch_cnt_t'(irq_stretch_cycles);

  stretch_cnt_t count;

  // Down-counter, a new pulse restarts the window
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      count <= '0;
    end else if (pulse) begin
      count <= cnt_load;
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  // Level follows the count one step ahead
  // so it drops together with the last count
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      irq_level <= 1'b0;
    end else begin
      irq_level <= pulse || (count > stretch_cnt_t'(1));
    end
  end

endmodule

// ==== design/status_sync.sv ====
// Status resynchroniser
// Brings the reference status group and both transceiver PLL lock lines
// into bus_clk through two-flop synchronisers and packs them into the
// daughterboard status word. Also samples the GPS PPS input for the
// processor GPIO through a three-stage shift register.

`timescale 1ns/1ps

module status_sync (
  input  logic                                      bus_clk,
  input  logic                                      bus_rst,
  input  logic [e31x_ctrl_pkg::tcxo_status_width-1:0] tcxo_status,
  input  logic                                      tx_pll_lock,
  input  logic                                      rx_pll_lock,
  input  logic                                      gps_pps,
  output logic [e31x_ctrl_pkg::reg_dwidth-1:0]        dboard_status,
  output logic                                      gps_pps_gpio
);

  import e31x_ctrl_pkg::*;

  localparam int stat_width = tcxo_status_width + 2;

  // Layout {tcxo_status, tx_pll_lock, rx_pll_lock}
  logic [stat_width-1:0] stat_meta;
  logic [stat_width-1:0] stat_sync;
  logic [2:0]            pps_shift;

  //////////////////////////////////////////////////////////////////////
  // Synchronisers
  //////////////////////////////////////////////////////////////////////

  // Inputs come from the reference clock and transceiver domains
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      stat_meta <= '0;
      stat_sync <= '0;
    end else begin
      stat_meta <= {tcxo_status, tx_pll_lock, rx_pll_lock};
      stat_sync <= stat_meta;
    end
  end

  // PPS toward the processor GPIO, used by ntpd
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      pps_shift <= '0;
    end else begin
      pps_shift <= {pps_shift[1:0], gps_pps};
    end
  end

  assign gps_pps_gpio = pps_shift[2];

  //////////////////////////////////////////////////////////////////////
  // Status word packing
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    dboard_status = '0;
    dboard_status[stat_tcxo_lsb +: tcxo_status_width] =
      stat_sync[stat_width-1 -: tcxo_status_width];
    dboard_status[stat_bit_tx_lock] = stat_sync[1];
    dboard_status[stat_bit_rx_lock] = stat_sync[0];
  end

endmodule

// ==== design/front_end_gpio.sv ====
// Front-end pin mapping
// Registers the per-channel daughterboard GPIO and LED words onto the
// TX enable and LED pins. Radio channel 1 drives the "1" pins and
// channel 0 drives the "2" pins. A pin whose direction bit is 0 is 0.

`timescale 1ns/1ps

module front_end_gpio (
  input  logic bus_clk,
  input  logic bus_rst,
  input  logic [e31x_ctrl_pkg::num_channels-1:0][e31x_ctrl_pkg::db_gpio_width-1:0] db_gpio_out,
  input  logic [e31x_ctrl_pkg::num_channels-1:0][e31x_ctrl_pkg::db_gpio_width-1:0] db_gpio_ddr,
  input  logic [e31x_ctrl_pkg::num_channels-1:0][e31x_ctrl_pkg::db_gpio_width-1:0] leds,
  output logic tx_enable1a,
  output logic tx_enable1b,
  output logic tx_enable2a,
  output logic tx_enable2b,
  output logic led_txrx1_rx,
  output logic led_txrx1_tx,
  output logic led_rx1_rx,
  output logic led_txrx2_rx,
  output logic led_txrx2_tx,
  output logic led_rx2_rx
);

  import e31x_ctrl_pkg::*;

  logic [num_channels-1:0]                tx_en_a_q;
  logic [num_channels-1:0]                tx_en_b_q;
  logic [num_channels-1:0][led_width-1:0] led_q;

  // Output bit only where the direction bit selects output
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      tx_en_a_q <= '0;
      tx_en_b_q <= '0;
      led_q     <= '0;
    end else begin
      for (int ch = 0; ch < num_channels; ch++) begin
        tx_en_a_q[ch] <= db_gpio_out[ch][gpio_bit_tx_enable_a] &
                         db_gpio_ddr[ch][gpio_bit_tx_enable_a];
        tx_en_b_q[ch] <= db_gpio_out[ch][gpio_bit_tx_enable_b] &
                         db_gpio_ddr[ch][gpio_bit_tx_enable_b];
        led_q[ch]     <= leds[ch][led_width-1:0];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Channel swap onto the board pins
  //////////////////////////////////////////////////////////////////////

  assign tx_enable1a  = tx_en_a_q[1];
  assign tx_enable1b  = tx_en_b_q[1];
  assign led_txrx1_rx = led_q[1][0];
  assign led_txrx1_tx = led_q[1][1];
  assign led_rx1_rx   = led_q[1][2];

  assign tx_enable2a  = tx_en_a_q[0];
  assign tx_enable2b  = tx_en_b_q[0];
  assign led_txrx2_rx = led_q[0][0];
  assign led_txrx2_tx = led_q[0][1];
  assign led_rx2_rx   = led_q[0][2];

endmodule

// ==== design/e31x_ctrl_top.sv ====
// E31x bus_clk housekeeping top level
// Power button interrupts, fabric-to-processor interrupt vector,
// daughterboard status word, GPS PPS sampling and front-end pin mapping.

`timescale 1ns/1ps

module e31x_ctrl_top (
  input  logic bus_clk,
  input  logic bus_rst,
  input  logic onswitch_n,
  input  logic pmu_irq,
  input  logic [e31x_ctrl_pkg::tcxo_status_width-1:0] tcxo_status,
  input  logic tx_pll_lock,
  input  logic rx_pll_lock,
  input  logic gps_pps,
  input  logic [e31x_ctrl_pkg::num_channels-1:0][e31x_ctrl_pkg::db_gpio_width-1:0] db_gpio_out,
  input  logic [e31x_ctrl_pkg::num_channels-1:0][e31x_ctrl_pkg::db_gpio_width-1:0] db_gpio_ddr,
  input  logic [e31x_ctrl_pkg::num_channels-1:0][e31x_ctrl_pkg::db_gpio_width-1:0] leds,
  output logic [e31x_ctrl_pkg::irq_width-1:0] irq_f2p,
  output logic [e31x_ctrl_pkg::reg_dwidth-1:0] dboard_status,
  output logic gps_pps_gpio,
  output logic tx_enable1a,
  output logic tx_enable1b,
  output logic tx_enable2a,
  output logic tx_enable2b,
  output logic led_txrx1_rx,
  output logic led_txrx1_tx,
  output logic led_rx1_rx,
  output logic led_txrx2_rx,
  output logic led_txrx2_tx,
  output logic led_rx2_rx
);

  import e31x_ctrl_pkg::*;

  logic press_pulse;
  logic release_pulse;
  logic press_irq;
  logic release_irq;

  //////////////////////////////////////////////////////////////////////
  // Power button
  //////////////////////////////////////////////////////////////////////

  power_button_fsm u_button (
    .bus_clk       (bus_clk),
    .bus_rst       (bus_rst),
    .onswitch_n    (onswitch_n),
    .press_pulse   (press_pulse),
    .release_pulse (release_pulse)
  );

  // Stretch so the processor does not miss them
  irq_stretch_timer u_press_stretch (
    .bus_clk   (bus_clk),
    .bus_rst   (bus_rst),
    .pulse     (press_pulse),
    .irq_level (press_irq)
  );

  irq_stretch_timer u_release_stretch (
    .bus_clk   (bus_clk),
    .bus_rst   (bus_rst),
    .pulse     (release_pulse),
    .irq_level (release_irq)
  );

  // Interrupt vector, pmu passes straight through
  always_comb begin
    irq_f2p                  = '0;
    irq_f2p[irq_bit_press]   = press_irq;
    irq_f2p[irq_bit_release] = release_irq;
    irq_f2p[irq_bit_pmu]     = pmu_irq;
  end

  //////////////////////////////////////////////////////////////////////
  // Status, PPS and front end
  //////////////////////////////////////////////////////////////////////

  status_sync u_status (
    .bus_clk       (bus_clk),
    .bus_rst       (bus_rst),
    .tcxo_status   (tcxo_status),
    .tx_pll_lock   (tx_pll_lock),
    .rx_pll_lock   (rx_pll_lock),
    .gps_pps       (gps_pps),
    .dboard_status (dboard_status),
    .gps_pps_gpio  (gps_pps_gpio)
  );

  front_end_gpio u_front_end (
    .bus_clk      (bus_clk),
    .bus_rst      (bus_rst),
    .db_gpio_out  (db_gpio_out),
    .db_gpio_ddr  (db_gpio_ddr),
    .leds         (leds),
    .tx_enable1a  (tx_enable1a),
    .tx_enable1b  (tx_enable1b),
    .tx_enable2a  (tx_enable2a),
    .tx_enable2b  (tx_enable2b),
    .led_txrx1_rx (led_txrx1_rx),
    .led_txrx1_tx (led_txrx1_tx),
    .led_rx1_rx   (led_rx1_rx),
    .led_txrx2_rx (led_txrx2_rx),
    .led_txrx2_tx (led_txrx2_tx),
    .led_rx2_rx   (led_rx2_rx)
  );

endmodule

// ==== verification/e31x_ctrl_checker.sv ====
// E31x interrupt vector checker
// Assertions on the fabric-to-processor interrupt vector, bound to the
// top level.

`timescale 1ns/1ps

module e31x_ctrl_checker (
  input logic                               bus_clk,
  input logic                               bus_rst,
  input logic [e31x_ctrl_pkg::irq_width-1:0] irq_f2p
);

  import e31x_ctrl_pkg::*;

  localparam logic [irq_width-1:0] irq_used_mask =
    (1 << irq_bit_press) | (1 << irq_bit_release) | (1 << irq_bit_pmu);

  // Number of failed assertions
  int unsigned assert_fail_count = 0;

  // Press interrupt holds for the whole stretch window
  press_stretch_len: assert property (
    @(posedge bus_clk) disable iff (bus_rst)
    $rose(irq_f2p[irq_bit_press]) |-> irq_f2p[irq_bit_press] [*irq_stretch_cycles]
  ) else begin
    $error("press interrupt shorter than the stretch length");
    assert_fail_count++;
  end

  // Unused vector bits stay low
  unused_irq_zero: assert property (
    @(posedge bus_clk) disable iff (bus_rst)
    (irq_f2p & ~irq_used_mask) == '0
  ) else begin
    $error("interrupt vector bit outside press, release and pmu is set");
    assert_fail_count++;
  end

  // First cycle out of reset has no release yet
  release_after_reset: assert property (
    @(posedge bus_clk)
    $fell(bus_rst) |-> !irq_f2p[irq_bit_release]
  ) else begin
    $error("release interrupt set in the first cycle after reset");
    assert_fail_count++;
  end

endmodule

bind e31x_ctrl_top e31x_ctrl_checker u_checker (
  .bus_clk (bus_clk),
  .bus_rst (bus_rst),
  .irq_f2p (irq_f2p)
);

// ==== verification/e31x_ctrl_tb.sv ====
// E31x housekeeping testbench
// Drives the button, status, PPS and front-end inputs of the top level,
// runs a cycle model next to the DUT and compares every output on the
// falling clock edge.

`timescale 1ns/1ps

module e31x_ctrl_tb;

  import e31x_ctrl_pkg::*;

  localparam int clk_period_ns  = 4;
  localparam int reset_cycles   = 4;
  localparam int rand_cycles    = 40;
  localparam int drain_cycles   = 5;
  localparam int stim_cycles    = reset_cycles + 20 + 40 + 25 + 2 * rand_cycles + drain_cycles;
  localparam int watchdog_ns    = (stim_cycles + 100) * clk_period_ns;

  typedef struct packed {
    logic [irq_width-1:0]  irq;
    logic [reg_dwidth-1:0] status;
    logic                  pps;
    logic [9:0]            pins;
  } expect_t;

  logic bus_clk;
  logic bus_rst;
  logic onswitch_n;
  logic pmu_irq;
  logic [tcxo_status_width-1:0] tcxo_status;
  logic tx_pll_lock;
  logic rx_pll_lock;
  logic gps_pps;
  logic [num_channels-1:0][db_gpio_width-1:0] db_gpio_out;
  logic [num_channels-1:0][db_gpio_width-1:0] db_gpio_ddr;
  logic [num_channels-1:0][db_gpio_width-1:0] leds;
  logic [irq_width-1:0]  irq_f2p;
  logic [reg_dwidth-1:0] dboard_status;
  logic gps_pps_gpio;
  logic tx_enable1a;
  logic tx_enable1b;
  logic tx_enable2a;
  logic tx_enable2b;
  logic led_txrx1_rx;
  logic led_txrx1_tx;
  logic led_rx1_rx;
  logic led_txrx2_rx;
  logic led_txrx2_tx;
  logic led_rx2_rx;

  // Model state
  logic [1:0]  btn_hist;
  logic        press_q;
  logic        release_q;
  int          press_rem;
  int          release_rem;
  logic [5:0]  stat_d1;
  logic [5:0]  stat_d2;
  logic [2:0]  pps_d;
  logic [9:0]  pins_q;
  expect_t     exp_now;
  logic        check_en;
  int          error_count;
  int          seed;
  logic [31:0] rnd;

  e31x_ctrl_top DUT (.*);

  initial begin
    bus_clk = 1'b0;
    forever #(clk_period_ns / 2) bus_clk = ~bus_clk;
  end

  initial begin
    #(watchdog_ns);
    $display("Watchdog timeout: the tests did not finish in time");
    $display("FAIL: see errors above");
    $fatal(1);
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // Pin order {tx1a, tx1b, tx2a, tx2b, txrx1 rx/tx, rx1, txrx2 rx/tx, rx2}
  function automatic logic [9:0] map_pins(
    input logic [num_channels-1:0][db_gpio_width-1:0] gpio_out,
    input logic [num_channels-1:0][db_gpio_width-1:0] gpio_ddr,
    input logic [num_channels-1:0][db_gpio_width-1:0] led_word
  );
    return {gpio_out[1][gpio_bit_tx_enable_a] & gpio_ddr[1][gpio_bit_tx_enable_a],
            gpio_out[1][gpio_bit_tx_enable_b] & gpio_ddr[1][gpio_bit_tx_enable_b],
            gpio_out[0][gpio_bit_tx_enable_a] & gpio_ddr[0][gpio_bit_tx_enable_a],
            gpio_out[0][gpio_bit_tx_enable_b] & gpio_ddr[0][gpio_bit_tx_enable_b],
            led_word[1][0], led_word[1][1], led_word[1][2],
            led_word[0][0], led_word[0][1], led_word[0][2]};
  endfunction

  function automatic expect_t ref_outputs(input logic pmu);
    expect_t e;
    e = '0;
    e.irq[irq_bit_press]   = (press_rem != 0);
    e.irq[irq_bit_release] = (release_rem != 0);
    e.irq[irq_bit_pmu]     = pmu;
    e.status[stat_tcxo_lsb +: tcxo_status_width] = stat_d2[5:2];
    e.status[stat_bit_tx_lock] = stat_d2[1];
    e.status[stat_bit_rx_lock] = stat_d2[0];
    e.pps  = pps_d[2];
    e.pins = pins_q;
    return e;
  endfunction

  // Reset history is two low samples so a high line releases once
  always @(posedge bus_clk) begin
    if (bus_rst) begin
      btn_hist    <= 2'b00;
      press_q     <= 1'b0;
      release_q   <= 1'b0;
      press_rem   <= 0;
      release_rem <= 0;
      stat_d1     <= '0;
      stat_d2     <= '0;
      pps_d       <= '0;
      pins_q      <= '0;
    end else begin
      press_q     <= !onswitch_n && (btn_hist == 2'b11);
      release_q   <= onswitch_n && (btn_hist == 2'b00);
      btn_hist    <= {btn_hist[0], onswitch_n};
      press_rem   <= press_q ? irq_stretch_cycles : (press_rem > 0 ? press_rem - 1 : 0);
      release_rem <= release_q ? irq_stretch_cycles : (release_rem > 0 ? release_rem - 1 : 0);
      stat_d1     <= {tcxo_status, tx_pll_lock, rx_pll_lock};
      stat_d2     <= stat_d1;
      pps_d       <= {pps_d[1:0], gps_pps};
      pins_q      <= map_pins(db_gpio_out, db_gpio_ddr, leds);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Comparison
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED at %0t ns: %s expected 0x%0h actual 0x%0h",
               $time, name, expected, actual);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  endtask

  always @(negedge bus_clk) begin
    if (check_en) begin
      exp_now = ref_outputs(pmu_irq);
      check_value("irq_f2p", 32'(exp_now.irq), 32'(irq_f2p));
      check_value("dboard_status", exp_now.status, dboard_status);
      check_value("gps_pps_gpio", 32'(exp_now.pps), 32'(gps_pps_gpio));
      check_value("tx_enable1a", 32'(exp_now.pins[9]), 32'(tx_enable1a));
      check_value("tx_enable1b", 32'(exp_now.pins[8]), 32'(tx_enable1b));
      check_value("tx_enable2a", 32'(exp_now.pins[7]), 32'(tx_enable2a));
      check_value("tx_enable2b", 32'(exp_now.pins[6]), 32'(tx_enable2b));
      check_value("led_txrx1_rx", 32'(exp_now.pins[5]), 32'(led_txrx1_rx));
      check_value("led_txrx1_tx", 32'(exp_now.pins[4]), 32'(led_txrx1_tx));
      check_value("led_rx1_rx", 32'(exp_now.pins[3]), 32'(led_rx1_rx));
      check_value("led_txrx2_rx", 32'(exp_now.pins[2]), 32'(led_txrx2_rx));
      check_value("led_txrx2_tx", 32'(exp_now.pins[1]), 32'(led_txrx2_tx));
      check_value("led_rx2_rx", 32'(exp_now.pins[0]), 32'(led_rx2_rx));
      check_value("checker_assert_failures", 32'd0,
                  32'(DUT.u_checker.assert_fail_count));
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic step_cycle();
    @(posedge bus_clk);
    #1;
  endtask

  task automatic hold_button(input logic level, input int cycles);
    onswitch_n = level;
    repeat (cycles) step_cycle();
  endtask

  initial begin
    seed        = 32'h202f25ec;
    error_count = 0;
    check_en    = 1'b0;
    bus_rst     = 1'b1;
    onswitch_n  = 1'b1;
    pmu_irq     = 1'b0;
    tcxo_status = '0;
    tx_pll_lock = 1'b0;
    rx_pll_lock = 1'b0;
    gps_pps     = 1'b0;
    db_gpio_out = '0;
    db_gpio_ddr = '0;
    leds        = '0;
    step_cycle();
    check_en = 1'b1;
    repeat (reset_cycles - 1) step_cycle();
    bus_rst = 1'b0;

    // Released button after reset, then a long press and release
    hold_button(1'b1, 20);
    hold_button(1'b0, 20);
    hold_button(1'b1, 20);

    // Glitch press, then a second press inside the stretch window
    hold_button(1'b0, 1);
    hold_button(1'b1, 3);
    hold_button(1'b0, 1);
    hold_button(1'b1, 20);

    // Status word and pmu pass-through
    repeat (rand_cycles) begin
      rnd         = $random(seed);
      tcxo_status = rnd[3:0];
      tx_pll_lock = rnd[4];
      rx_pll_lock = rnd[5];
      pmu_irq     = rnd[6];
      step_cycle();
    end
    pmu_irq = 1'b0;

    // Front-end words and PPS toggles
    for (int i = 0; i < rand_cycles; i++) begin
      for (int ch = 0; ch < num_channels; ch++) begin
        db_gpio_out[ch] = $random(seed);
        db_gpio_ddr[ch] = $random(seed);
        leds[ch]        = $random(seed);
      end
      if (i % 5 == 0) begin
        gps_pps = ~gps_pps;
      end
      step_cycle();
    end
    repeat (drain_cycles) step_cycle();

    if (error_count == 0 && DUT.u_checker.assert_fail_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
design/e31x_ctrl_pkg.sv
design/power_button_fsm.sv
design/irq_stretch_timer.sv
design/status_sync.sv
design/front_end_gpio.sv
design/e31x_ctrl_top.sv
verification/e31x_ctrl_checker.sv
verification/e31x_ctrl_tb.sv

// ==== Bender.yml ====
package:
  name: e31x_ctrl

sources:
  - design/e31x_ctrl_pkg.sv
  - design/power_button_fsm.sv
  - design/irq_stretch_timer.sv
  - design/status_sync.sv
  - design/front_end_gpio.sv
  - design/e31x_ctrl_top.sv
  - target: simulation
    files:
      - verification/e31x_ctrl_checker.sv
      - verification/e31x_ctrl_tb.sv
